// ==== sources.f ====
hw/ts3d_pkg.sv
hw/act_buffer.sv
hw/act_unpacker.sv
hw/act_distributor.sv
hw/pe_lane.sv
hw/pool_max.sv
hw/ts3d_top.sv
test/tb_ts3d.sv

// ==== Bender.yml ====
package:
  name: ts3d

sources:
  - files:
      - hw/ts3d_pkg.sv
      - hw/act_buffer.sv
      - hw/act_unpacker.sv
      - hw/act_distributor.sv
      - hw/pe_lane.sv
      - hw/pool_max.sv
      - hw/ts3d_top.sv
  - target: test
    files:
      - test/tb_ts3d.sv

// ==== test/tb_ts3d.sv ====
// self-checking testbench; weights reload only when no patch is pending, writer bounds occupancy
`timescale 1ns/1ps

module tb_ts3d
    import ts3d_pkg::*;
();

    localparam int WORDS_PER_PATCH = PATCH_LEN / ACTS_PER_WORD;
    localparam int RESET_CYCLES    = 8;
    localparam int RANDOM_PATCHES  = 20;
    localparam int FILL_PATCHES    = BUF_DEPTH / WORDS_PER_PATCH + 8;
    localparam int RELOAD_ROUNDS   = 2;
    localparam int TOTAL_PATCHES   = 1 + RANDOM_PATCHES + FILL_PATCHES + 2 * RELOAD_ROUNDS;
    // five unpack slots per word plus one write slot, four times over
    localparam int PATCH_CYCLES    = WORDS_PER_PATCH * (ACTS_PER_WORD + 2);
    localparam int MAX_CYCLES      = 4 * (RESET_CYCLES + TOTAL_PATCHES * PATCH_CYCLES);

    logic                  clk;
    logic                  rst_n;
    logic                  act_en_wr;
    logic [BUF_ADDR_W-1:0] act_addr_wr;
    logic [PORT_W-1:0]     act_dat_wr;
    logic                  act_buf_full;
    logic                  wei_en;
    logic [LANE_IDX_W-1:0] wei_lane;
    logic [WEI_W-1:0]      wei_dat;
    logic                  ofm_en_wr;
    logic [OFM_ADDR_W-1:0] ofm_addr_wr;
    logic [PSUM_W-1:0]     ofm_dat;

    int                            seed = 32'h1d12;
    int                            errors;
    int                            checks;
    int                            tests_done;
    int                            cycles;
    int                            words_written;
    int                            results_seen;
    int                            exp_dat_q [$];
    logic [OFM_ADDR_W-1:0]         exp_addr;
    logic [BUF_ADDR_W-1:0]         wr_addr;
    logic [NUM_PE-1:0][WEI_W-1:0]  cur_w;
    logic                          full_seen;

    ts3d_top u_ts3d_top (
        .clk          (clk),
        .rst_n        (rst_n),
        .act_en_wr    (act_en_wr),
        .act_addr_wr  (act_addr_wr),
        .act_dat_wr   (act_dat_wr),
        .act_buf_full (act_buf_full),
        .wei_en       (wei_en),
        .wei_lane     (wei_lane),
        .wei_dat      (wei_dat),
        .ofm_en_wr    (ofm_en_wr),
        .ofm_addr_wr  (ofm_addr_wr),
        .ofm_dat      (ofm_dat)
    );

    always #2 clk = ~clk;

    // ======================================================================
    // reference model and checking
    // ======================================================================

    // lane k sees activations k, k+4, k+8, k+12 of the patch
    function automatic int max_lane_sum(input logic [PATCH_LEN-1:0][ACT_W-1:0] acts,
                                        input logic [NUM_PE-1:0][WEI_W-1:0] w);
        int best;
        int sum;
        best = 0;
        for (int k = 0; k < NUM_PE; k++) begin
            sum = 0;
            for (int j = 0; j < LEN_PSUM; j++) begin
                sum = sum + w[k] * acts[k + NUM_PE * j];
            end
            if (sum > best) begin
                best = sum;
            end
        end
        return best;
    endfunction

    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAIL %0t: %s is %0d, expected %0d", $time, what, got, exp);
        end
    endtask

    // output port sampled mid-cycle
    always @(negedge clk) begin
        if (rst_n && ofm_en_wr) begin
            results_seen++;
            if (exp_dat_q.size() == 0) begin
                errors++;
                $display("output write at %0t arrived with no patch pending", $time);
            end else begin
                check_value("ofm_dat", ofm_dat, exp_dat_q.pop_front());
                check_value("ofm_addr_wr", ofm_addr_wr, exp_addr);
                exp_addr = exp_addr + 1'b1;
            end
        end
    end

    always @(negedge clk) begin
        if (act_buf_full) begin
            full_seen = 1'b1;
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= MAX_CYCLES) begin
            $display("timeout: run did not finish within %0d cycles", MAX_CYCLES);
            $display("ERRORS FOUND");
            $finish;
        end
    end

    // ======================================================================
    // stimulus tasks
    // ======================================================================

    // occupancy bound counts every word not yet turned into a result
    task automatic write_word(input logic [PORT_W-1:0] word);
        logic room;
        room = 1'b0;
        while (!room) begin
            @(posedge clk);
            room = !act_buf_full &&
                   (words_written - WORDS_PER_PATCH * results_seen < BUF_DEPTH);
            if (room) begin
                act_en_wr   <= 1'b1;
                act_addr_wr <= wr_addr;
                act_dat_wr  <= word;
                wr_addr     = wr_addr + 1'b1;
                words_written++;
            end else begin
                act_en_wr <= 1'b0;
            end
        end
    endtask

    task automatic write_patch(input logic [WORDS_PER_PATCH-1:0][PORT_W-1:0] words);
        logic [PATCH_LEN-1:0][ACT_W-1:0] acts;
        for (int i = 0; i < WORDS_PER_PATCH; i++) begin
            for (int b = 0; b < ACTS_PER_WORD; b++) begin
                acts[ACTS_PER_WORD * i + b] = words[i][PORT_W - 1 - ACT_W * b -: ACT_W];
            end
        end
        exp_dat_q.push_back(max_lane_sum(acts, cur_w));
        for (int i = 0; i < WORDS_PER_PATCH; i++) begin
            write_word(words[i]);
        end
    endtask

    task automatic write_random_patch();
        logic [WORDS_PER_PATCH-1:0][PORT_W-1:0] words;
        for (int i = 0; i < WORDS_PER_PATCH; i++) begin
            words[i] = $random(seed);
        end
        write_patch(words);
    endtask

    task automatic load_weights(input logic [NUM_PE-1:0][WEI_W-1:0] w);
        for (int k = 0; k < NUM_PE; k++) begin
            @(posedge clk);
            wei_en   <= 1'b1;
            wei_lane <= LANE_IDX_W'(k);
            wei_dat  <= w[k];
        end
        @(posedge clk);
        wei_en <= 1'b0;
        cur_w = w;
    endtask

    task automatic load_random_weights();
        logic [NUM_PE-1:0][WEI_W-1:0] w;
        logic [31:0]                  r;
        for (int k = 0; k < NUM_PE; k++) begin
            r    = $random(seed);
            w[k] = r[WEI_W-1:0];
        end
        load_weights(w);
    endtask

    task automatic wait_drain();
        @(posedge clk);
        act_en_wr <= 1'b0;
        while (exp_dat_q.size() != 0) begin
            @(posedge clk);
        end
    endtask

    task automatic finish_test(input string name);
        tests_done++;
        $display("test %0d (%s) finished, %0d errors so far", tests_done, name, errors);
    endtask

    // ======================================================================
    // test sequence
    // ======================================================================

    initial begin
        clk         = 1'b0;
        rst_n       = 1'b0;
        act_en_wr   = 1'b0;
        act_addr_wr = '0;
        act_dat_wr  = '0;
        wei_en      = 1'b0;
        wei_lane    = '0;
        wei_dat     = '0;
        exp_addr    = '0;
        wr_addr     = '0;
        cur_w       = '0;
        full_seen   = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        rst_n <= 1'b1;

        // quiet after reset, no writes
        @(negedge clk);
        check_value("ofm_en_wr after reset", ofm_en_wr, 0);
        check_value("act_buf_full after reset", act_buf_full, 0);
        check_value("ofm_addr_wr after reset", ofm_addr_wr, 0);
        repeat (4 * PATCH_LEN) @(posedge clk);
        finish_test("idle after reset");

        load_weights({8'd2, 8'd7, 8'd1, 8'd3});
        write_patch({32'h03a05511, 32'h7f0e0fc0, 32'h20018040, 32'h10ff0203});
        wait_drain();
        finish_test("single fixed patch");

        load_random_weights();
        repeat (RANDOM_PATCHES) write_random_patch();
        wait_drain();
        finish_test("random patches back to back");

        full_seen = 1'b0;
        repeat (FILL_PATCHES) write_random_patch();
        wait_drain();
        check_value("act_buf_full reached", full_seen, 1);
        finish_test("buffer fill");

        for (int r = 0; r < RELOAD_ROUNDS; r++) begin
            load_random_weights();
            write_random_patch();
            write_random_patch();
            wait_drain();
        end
        finish_test("weight reload");

        $display("%0d tests, %0d checks, %0d errors", tests_done, checks, errors);
        if (errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

// ==== hw/ts3d_top.sv ====
// activation datapath top; no handshake beyond act_buf_full, output port never stalls
`timescale 1ns/1ps

module ts3d_top
    import ts3d_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  act_en_wr,
    input  logic [BUF_ADDR_W-1:0] act_addr_wr,
    input  logic [PORT_W-1:0]     act_dat_wr,
    output logic                  act_buf_full,
    input  logic                  wei_en,
    input  logic [LANE_IDX_W-1:0] wei_lane,
    input  logic [WEI_W-1:0]      wei_dat,
    output logic                  ofm_en_wr,
    output logic [OFM_ADDR_W-1:0] ofm_addr_wr,
    output logic [PSUM_W-1:0]     ofm_dat
);

    logic                          buf_val_rd;
    logic [PORT_W-1:0]             buf_dat_rd;
    logic                          unpack_empty;
    logic                          act_val;
    logic [ACT_W-1:0]              act_dat;
    logic [NUM_PE-1:0]             lane_act_en;
    logic [ACT_W-1:0]              lane_act;
    logic [NUM_PE-1:0]             lane_wei_en;
    logic [WEI_W-1:0]              lane_wei;
    logic [NUM_PE-1:0][PSUM_W-1:0] lane_psum;
    logic                          lane_done;

    act_buffer u_act_buffer (
        .clk          (clk),
        .rst_n        (rst_n),
        .act_en_wr    (act_en_wr),
        .act_addr_wr  (act_addr_wr),
        .act_dat_wr   (act_dat_wr),
        .unpack_empty (unpack_empty),
        .buf_val_rd   (buf_val_rd),
        .buf_dat_rd   (buf_dat_rd),
        .act_buf_full (act_buf_full)
    );

    act_unpacker u_act_unpacker (
        .clk          (clk),
        .rst_n        (rst_n),
        .buf_val_rd   (buf_val_rd),
        .buf_dat_rd   (buf_dat_rd),
        .unpack_empty (unpack_empty),
        .act_val      (act_val),
        .act_dat      (act_dat)
    );

    act_distributor u_act_distributor (
        .clk         (clk),
        .rst_n       (rst_n),
        .act_val     (act_val),
        .act_dat     (act_dat),
        .wei_en      (wei_en),
        .wei_lane    (wei_lane),
        .wei_dat     (wei_dat),
        .lane_act_en (lane_act_en),
        .lane_act    (lane_act),
        .lane_wei_en (lane_wei_en),
        .lane_wei    (lane_wei)
    );

    // ======================================================================
    // lane array, only the last lane reports completion
    // ======================================================================

    for (genvar k = 0; k < NUM_PE; k++) begin : g_lane
        if (k == NUM_PE - 1) begin : g_last
            pe_lane u_pe_lane (
                .clk         (clk),
                .rst_n       (rst_n),
                .lane_act_en (lane_act_en[k]),
                .lane_act    (lane_act),
                .lane_wei_en (lane_wei_en[k]),
                .lane_wei    (lane_wei),
                .lane_psum   (lane_psum[k]),
                .lane_done   (lane_done)
            );
        end else begin : g_other
            pe_lane u_pe_lane (
                .clk         (clk),
                .rst_n       (rst_n),
                .lane_act_en (lane_act_en[k]),
                .lane_act    (lane_act),
                .lane_wei_en (lane_wei_en[k]),
                .lane_wei    (lane_wei),
                .lane_psum   (lane_psum[k]),
                .lane_done   ()
            );
        end
    end

    pool_max u_pool_max (
        .clk         (clk),
        .rst_n       (rst_n),
        .lane_done   (lane_done),
        .lane_psum   (lane_psum),
        .ofm_en_wr   (ofm_en_wr),
        .ofm_addr_wr (ofm_addr_wr),
        .ofm_dat     (ofm_dat)
    );

endmodule

// ==== hw/pool_max.sv ====
// max pooling over all lanes, triggered by the last lane; other lane results must already be held
`timescale 1ns/1ps

module pool_max
    import ts3d_pkg::*;
(
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          lane_done,
    input  logic [NUM_PE-1:0][PSUM_W-1:0] lane_psum,
    output logic                          ofm_en_wr,
    output logic [OFM_ADDR_W-1:0]         ofm_addr_wr,
    output logic [PSUM_W-1:0]             ofm_dat
);

    logic [PSUM_W-1:0] psum_max;

    // linear compare chain, small enough for NUM_PE lanes
    always_comb begin
        psum_max = lane_psum[0];
        for (int k = 1; k < NUM_PE; k++) begin
            if (lane_psum[k] > psum_max) begin
                psum_max = lane_psum[k];
            end
        end
    end

    // ======================================================================
    // output write port
    // ======================================================================

    always_ff @(posedge clk) begin
        if (lane_done) begin
            ofm_dat <= psum_max;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ofm_en_wr <= 1'b0;
        end else begin
            ofm_en_wr <= lane_done;
        end
    end

    // address moves on after the strobe, wraps
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ofm_addr_wr <= '0;
        end else if (ofm_en_wr) begin
            ofm_addr_wr <= ofm_addr_wr + 1'b1;
        end
    end

endmodule

// ==== hw/pe_lane.sv ====
// one MAC lane; the weight must not change while a patch is in progress
`timescale 1ns/1ps

module pe_lane
    import ts3d_pkg::*;
(
    input  logic              clk,
    input  logic              rst_n,
    input  logic              lane_act_en,
    input  logic [ACT_W-1:0]  lane_act,
    input  logic              lane_wei_en,
    input  logic [WEI_W-1:0]  lane_wei,
    output logic [PSUM_W-1:0] lane_psum,
    output logic              lane_done
);

    logic [WEI_W-1:0]             wei_q;
    logic [PSUM_W-1:0]            acc;
    logic [$clog2(LEN_PSUM)-1:0]  cnt;
    logic [ACT_W+WEI_W-1:0]       prod;
    logic [PSUM_W-1:0]            acc_next;
    logic                         last_act;

    // unsigned product, widened before the add
    assign prod     = lane_act * wei_q;
    assign acc_next = acc + PSUM_W'(prod);
    assign last_act = (cnt == ($clog2(LEN_PSUM))'(LEN_PSUM - 1));

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wei_q <= '0;
        end else if (lane_wei_en) begin
            wei_q <= lane_wei;
        end
    end

    // ======================================================================
    // accumulate over one patch
    // ======================================================================

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            acc <= '0;
            cnt <= '0;
        end else if (lane_act_en) begin
            if (last_act) begin
                acc <= '0;
                cnt <= '0;
            end else begin
                acc <= acc_next;
                cnt <= cnt + 1'b1;
            end
        end
    end

    // result held until the next patch completes
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            lane_psum <= '0;
            lane_done <= 1'b0;
        end else begin
            lane_done <= lane_act_en && last_act;
            if (lane_act_en && last_act) begin
                lane_psum <= acc_next;
            end
        end
    end

endmodule

// ==== hw/act_distributor.sv ====
// round-robin dealer; patch alignment relies on PATCH_LEN being a multiple of NUM_PE
`timescale 1ns/1ps

module act_distributor
    import ts3d_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  act_val,
    input  logic [ACT_W-1:0]      act_dat,
    input  logic                  wei_en,
    input  logic [LANE_IDX_W-1:0] wei_lane,
    input  logic [WEI_W-1:0]      wei_dat,
    output logic [NUM_PE-1:0]     lane_act_en,
    output logic [ACT_W-1:0]      lane_act,
    output logic [NUM_PE-1:0]     lane_wei_en,
    output logic [WEI_W-1:0]      lane_wei
);

    logic [LANE_IDX_W-1:0] lane_ptr;

    // shared data, per-lane strobes
    assign lane_act = act_dat;
    assign lane_wei = wei_dat;

    always_comb begin
        for (int k = 0; k < NUM_PE; k++) begin
            lane_act_en[k] = act_val && (lane_ptr == LANE_IDX_W'(k));
            lane_wei_en[k] = wei_en && (wei_lane == LANE_IDX_W'(k));
        end
    end

    // next lane to receive an activation
    // wraps at the top of the index range
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            lane_ptr <= '0;
        end else if (act_val) begin
            lane_ptr <= lane_ptr + 1'b1;
        end
    end

endmodule

// ==== hw/act_unpacker.sv ====
// left-first unpacker; a new word is only expected while unpack_empty is high
`timescale 1ns/1ps

module act_unpacker
    import ts3d_pkg::*;
(
    input  logic              clk,
    input  logic              rst_n,
    input  logic              buf_val_rd,
    input  logic [PORT_W-1:0] buf_dat_rd,
    output logic              unpack_empty,
    output logic              act_val,
    output logic [ACT_W-1:0]  act_dat
);

    logic [PORT_W-1:0]                    shift_q;
    logic [$clog2(ACTS_PER_WORD + 1)-1:0] remain;

    // ======================================================================
    // output side
    // ======================================================================

    assign act_val = (remain != '0);
    assign act_dat = shift_q[PORT_W-1 -: ACT_W];

    // high already while the last byte goes out, so the next read overlaps
    assign unpack_empty = (remain <= 1);

    // ======================================================================
    // word register
    // ======================================================================

    // top byte leaves first, rest moves up
    always_ff @(posedge clk) begin
        if (buf_val_rd) begin
            shift_q <= buf_dat_rd;
        end else if (act_val) begin
            shift_q <= shift_q << ACT_W;
        end
    end

    // activations still to hand out
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            remain <= '0;
        end else if (buf_val_rd) begin
            remain <= ($clog2(ACTS_PER_WORD + 1))'(ACTS_PER_WORD);
        end else if (act_val) begin
            remain <= remain - 1'b1;
        end
    end

endmodule

// ==== hw/act_buffer.sv ====
// single port activation RAM; writer must hold off while act_buf_full is high and write in order
`timescale 1ns/1ps

module act_buffer
    import ts3d_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  act_en_wr,
    input  logic [BUF_ADDR_W-1:0] act_addr_wr,
    input  logic [PORT_W-1:0]     act_dat_wr,
    input  logic                  unpack_empty,
    output logic                  buf_val_rd,
    output logic [PORT_W-1:0]     buf_dat_rd,
    output logic                  act_buf_full
);

    logic [PORT_W-1:0]     mem [BUF_DEPTH];
    logic [BUF_ADDR_W:0]   count;
    logic [BUF_ADDR_W-1:0] rd_addr;
    logic                  rd_en;

    // ======================================================================
    // read arbitration
    // ======================================================================

    // write wins the port, and only one word may be in flight
    assign rd_en = (count != '0) && unpack_empty && !act_en_wr && !buf_val_rd;

    assign act_buf_full = (count == (BUF_ADDR_W + 1)'(BUF_DEPTH));

    // ======================================================================
    // RAM, one access per cycle
    // ======================================================================

    always_ff @(posedge clk) begin
        if (act_en_wr) begin
            mem[act_addr_wr] <= act_dat_wr;
        end else if (rd_en) begin
            buf_dat_rd <= mem[rd_addr];
        end
    end

    // read data valid one cycle after the read
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            buf_val_rd <= 1'b0;
        end else begin
            buf_val_rd <= rd_en;
        end
    end

    // read pointer, wraps with the RAM
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_addr <= '0;
        end else if (rd_en) begin
            rd_addr <= rd_addr + 1'b1;
        end
    end

    // occupancy, never both directions in one cycle
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            count <= '0;
        end else if (act_en_wr) begin
            count <= count + 1'b1;
        end else if (rd_en) begin
            count <= count - 1'b1;
        end
    end

endmodule

// ==== hw/ts3d_pkg.sv ====
// datapath widths and sizes; NUM_PE and BUF_DEPTH must stay powers of two matching their index widths
package ts3d_pkg;

    // ======================================================================
    // port and activation widths
    // ======================================================================

    // one buffer word as seen on the external write port
    localparam int PORT_W        = 32;

    // one activation, unpacked most significant byte first
    localparam int ACT_W         = 8;
    localparam int ACTS_PER_WORD = PORT_W / ACT_W;

    // weights are unsigned, one register per lane
    localparam int WEI_W         = 8;

    // ======================================================================
    // lane array
    // ======================================================================

    localparam int NUM_PE        = 4;
    localparam int LANE_IDX_W    = 2;

    // activations per lane per patch
    localparam int LEN_PSUM      = 4;
    localparam int PATCH_LEN     = NUM_PE * LEN_PSUM;

    // 16 bit product, four of them summed, plus margin
    localparam int PSUM_W        = 20;

    // ======================================================================
    // buffers and output
    // ======================================================================

    localparam int BUF_ADDR_W    = 6;
    localparam int BUF_DEPTH     = 64;

    // output address wraps after 2**OFM_ADDR_W results
    localparam int OFM_ADDR_W    = 6;

endpackage
